// File: tag_pkg.sv
package tag_pkg;

	////////////////////////////////////////////////////////////
	// tag pool sizing
	////////////////////////////////////////////////////////////

	// host link tags are one byte wide
	localparam int tag_width = 8;

	// compute unit number carried in each record
	localparam int cu_id_width = 6;

	////////////////////////////////////////////////////////////
	// command record
	////////////////////////////////////////////////////////////

	// kind of command a tag was issued for
	typedef enum logic [1:0] {
		cmd_read     = 2'b00,
		cmd_write    = 2'b01,
		cmd_prefetch = 2'b10,
		cmd_flush    = 2'b11
	} cmd_type_t;

	// one record per outstanding tag
	// looked up again when the response comes back
	typedef struct packed {
		cmd_type_t               cmd_type;
		logic [cu_id_width-1:0]  cu_id;
	} tag_line_t;

	////////////////////////////////////////////////////////////
	// controller states
	////////////////////////////////////////////////////////////

	// reset clears the fill counter
	// fill loads the free-tag FIFO one tag per cycle
	// ready serves commands and returns
	typedef enum logic [1:0] {
		state_reset = 2'b00,
		state_fill  = 2'b01,
		state_ready = 2'b10
	} tag_state_t;

endpackage

// File: fifo_if.sv
`timescale 1ns/1ps

interface fifo_if import tag_pkg::*; ();

	// write side, owned by the controller
	logic                 push;
	logic [tag_width-1:0] data_in;
	logic                 flush;

	// read side, head is popped at the edge
	logic                 pop;
	logic [tag_width-1:0] data_out;

	// occupancy status from the buffer
	logic                 empty;
	logic                 almost_full;
	logic                 full;

	// controller steers push and pop
	modport ctrl (
		output push, data_in, flush, pop,
		input  data_out, empty, almost_full, full
	);

	// free-tag buffer side
	modport buffer (
		input  push, data_in, flush, pop,
		output data_out, empty, almost_full, full
	);

endinterface

// File: tag_fifo.sv
`timescale 1ns/1ps

module tag_fifo import tag_pkg::*; #(
	parameter int depth = 256
) (
	input logic        clock,
	input logic        rstn,
	fifo_if.buffer     fifo
);

	// pointer and occupancy widths
	localparam int aw = $clog2(depth);
	localparam int cw = $clog2(depth + 1);

	// free tag storage
	logic [tag_width-1:0] mem [depth];

	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [cw-1:0] count;

	logic do_push;
	logic do_pop;

	////////////////////////////////////////////////////////////
	// qualified strobes
	////////////////////////////////////////////////////////////

	// pop only a real entry
	assign do_pop  = fifo.pop && !fifo.empty;
	// a full buffer still takes a push when the head leaves
	assign do_push = fifo.push && (!fifo.full || do_pop);

	////////////////////////////////////////////////////////////
	// pointers and count
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (fifo.flush) begin
			// flush wins over push and pop
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				// wrap at depth which need not be a power of two
				wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// write port
	always_ff @(posedge clock) begin
		if (do_push && !fifo.flush) begin
			mem[wr_ptr] <= fifo.data_in;
		end
	end

	////////////////////////////////////////////////////////////
	// head and status
	////////////////////////////////////////////////////////////

	// show-ahead head visible while not empty
	assign fifo.data_out    = mem[rd_ptr];
	assign fifo.empty       = (count == '0);
	assign fifo.almost_full = (count == cw'(depth - 1));
	assign fifo.full        = (count == cw'(depth));

	// underflow means a tag was issued twice
	a_no_pop_empty: assert property (@(posedge clock) disable iff (!rstn)
		fifo.pop && !fifo.flush |-> !fifo.empty);

	// overflow means a tag came back that was never issued
	a_no_push_full: assert property (@(posedge clock) disable iff (!rstn)
		fifo.push && fifo.full && !fifo.flush |-> fifo.pop);

endmodule

// File: tag_ram.sv
`timescale 1ns/1ps

module tag_ram import tag_pkg::*; (
	input  logic                 clock,

	// record write at command issue
	input  logic                 we,
	input  logic [tag_width-1:0] wr_addr,
	input  tag_line_t            wr_line,

	// lookup for the response path
	input  logic [tag_width-1:0] rd_addr1,
	output tag_line_t            rd_line1,

	// lookup for the read-data path
	input  logic [tag_width-1:0] rd_addr2,
	output tag_line_t            rd_line2
);

	////////////////////////////////////////////////////////////
	// one record per possible tag value
	////////////////////////////////////////////////////////////

	// full tag space, independent of pool size
	tag_line_t mem [2**tag_width];

	// write port
	always_ff @(posedge clock) begin
		if (we) begin
			mem[wr_addr] <= wr_line;
		end
	end

	// two registered read ports
	// same-address write in the same cycle returns the old record
	always_ff @(posedge clock) begin
		rd_line1 <= mem[rd_addr1];
		rd_line2 <= mem[rd_addr2];
	end

endmodule

// File: tag_control.sv
`timescale 1ns/1ps

module tag_control import tag_pkg::*; #(
	parameter int tag_count = 256
) (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 enable,

	// command issue and tag return strobes
	input  logic                 command_valid,
	input  logic                 response_valid,
	input  logic [tag_width-1:0] response_tag,

	// high while a free tag is on offer
	output logic                 tag_ready,

	fifo_if.ctrl                 fifo
);

	tag_state_t state;
	tag_state_t next_state;

	// one bit wider so tag_count of 256 fits
	logic [tag_width:0] fill_count;
	logic               last_fill;

	// last tag of the pool is being pushed
	assign last_fill = (fill_count == (tag_width + 1)'(tag_count - 1));

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= state_reset;
		end else if (!enable) begin
			// disabled, restart from reset
			state <= state_reset;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			state_reset: begin
				next_state = state_fill;
			end
			state_fill: begin
				// stop after the last pool tag goes in
				if (last_fill) begin
					next_state = state_ready;
				end
			end
			state_ready: begin
				next_state = state_ready;
			end
			default: begin
				next_state = state_reset;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// fill counter
	////////////////////////////////////////////////////////////

	// counts tags 0 to tag_count-1
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			fill_count <= '0;
		end else if (!enable || state != state_fill) begin
			fill_count <= '0;
		end else begin
			fill_count <= fill_count + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// FIFO steering
	////////////////////////////////////////////////////////////

	always_comb begin
		fifo.push    = 1'b0;
		fifo.pop     = 1'b0;
		fifo.data_in = response_tag;
		case (state)
			state_fill: begin
				// one pool tag per cycle
				fifo.push    = 1'b1;
				fifo.data_in = fill_count[tag_width-1:0];
			end
			state_ready: begin
				// returned tag back into the pool
				fifo.push = response_valid;
				// issued tag leaves the head
				fifo.pop  = command_valid;
			end
			default: begin
				fifo.push = 1'b0;
				fifo.pop  = 1'b0;
			end
		endcase
	end

	// pool is cleared while disabled
	assign fifo.flush = !enable;

	assign tag_ready = (state == state_ready) && !fifo.empty;

	// requester must wait for a free tag
	a_cmd_when_ready: assert property (@(posedge clock) disable iff (!rstn)
		command_valid |-> tag_ready);

	// a return into a full pool with nothing leaving
	a_no_overflow: assert property (@(posedge clock) disable iff (!rstn)
		(state == state_ready) && response_valid && fifo.full |-> command_valid);

	// fill ends with exactly the whole pool in the buffer
	a_fill_full: assert property (@(posedge clock) disable iff (!rstn)
		(state == state_fill) && last_fill && enable |->
			fifo.almost_full ##1 fifo.full);

endmodule

// File: tag_manager.sv
`timescale 1ns/1ps

module tag_manager import tag_pkg::*; #(
	parameter int tag_count = 256
) (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 enable,

	// command side
	input  logic                 command_valid,
	input  tag_line_t            command_line,
	output logic [tag_width-1:0] command_tag,
	output logic                 tag_ready,

	// response side
	input  logic                 response_valid,
	input  logic [tag_width-1:0] response_tag,
	output tag_line_t            response_line,

	// read-data side
	input  logic [tag_width-1:0] data_read_tag,
	output tag_line_t            data_read_line
);

	////////////////////////////////////////////////////////////
	// free-tag pool
	////////////////////////////////////////////////////////////

	fifo_if tag_fifo_bus ();

	// sequencing and push/pop steering
	tag_control #(
		.tag_count      (tag_count)
	) i_tag_control (
		.clock          (clock),
		.rstn           (rstn),
		.enable         (enable),
		.command_valid  (command_valid),
		.response_valid (response_valid),
		.response_tag   (response_tag),
		.tag_ready      (tag_ready),
		.fifo           (tag_fifo_bus)
	);

	// one slot per pool tag
	tag_fifo #(
		.depth          (tag_count)
	) i_tag_fifo (
		.clock          (clock),
		.rstn           (rstn),
		.fifo           (tag_fifo_bus)
	);

	// head of the pool is the tag on offer
	assign command_tag = tag_fifo_bus.data_out;

	////////////////////////////////////////////////////////////
	// tag to compute unit bookkeeping
	////////////////////////////////////////////////////////////

	// record written at the issued tag
	tag_ram i_tag_ram (
		.clock          (clock),
		.we             (command_valid),
		.wr_addr        (command_tag),
		.wr_line        (command_line),
		.rd_addr1       (response_tag),
		.rd_line1       (response_line),
		.rd_addr2       (data_read_tag),
		.rd_line2       (data_read_line)
	);

endmodule

// File: tb_tag_manager.sv
`timescale 1ns/1ps

module tb_tag_manager import tag_pkg::*; ();

	// small pool keeps fill and exhaustion short
	localparam int tag_count     = 16;
	localparam int book_count    = 12;
	localparam int read_count    = 12;
	localparam int random_cycles = 400;

	// rough cycle cost of every test
	// watchdog adds half again
	localparam int total_cycles = 11 + 2 * (2 * tag_count + 12) + (2 * tag_count + 5)
		+ 2 * book_count + (2 * book_count + read_count) + random_cycles + tag_count + 8;
	localparam int watchdog_cycles = total_cycles + total_cycles / 2 + 50;

	// predicted DUT state for one rising edge
	typedef struct packed {
		logic                 ready;
		logic [tag_width-1:0] tag;
		tag_line_t            line;
	} expected_t;

	logic                 clock;
	logic                 rstn;
	logic                 enable;
	logic                 command_valid;
	tag_line_t            command_line;
	logic [tag_width-1:0] command_tag;
	logic                 tag_ready;
	logic                 response_valid;
	logic [tag_width-1:0] response_tag;
	tag_line_t            response_line;
	logic [tag_width-1:0] data_read_tag;
	tag_line_t            data_read_line;

	// reference model of free pool order and per-tag records
	logic [tag_width-1:0] free_q[$];
	tag_line_t            rec [2**tag_width];
	bit                   written [2**tag_width];
	int                   fill_edges;

	// registered lookups due on the next edge
	bit                   resp_pending;
	bit                   data_pending;
	tag_line_t            resp_expect;
	tag_line_t            data_expect;

	// tags the requester holds
	logic [tag_width-1:0] outstanding[$];

	int                   reads_checked;
	string                test_name;

	tag_manager #(
		.tag_count      (tag_count)
	) i_tag_manager (
		.clock          (clock),
		.rstn           (rstn),
		.enable         (enable),
		.command_valid  (command_valid),
		.command_line   (command_line),
		.command_tag    (command_tag),
		.tag_ready      (tag_ready),
		.response_valid (response_valid),
		.response_tag   (response_tag),
		.response_line  (response_line),
		.data_read_tag  (data_read_tag),
		.data_read_line (data_read_line)
	);

	initial begin : clock_gen
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// reference model and compare
	////////////////////////////////////////////////////////////

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
			$display("Finished with errors");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// ready after fill with something in the pool
	// head is the next tag
	function automatic expected_t predict_outputs(input logic [tag_width-1:0] lookup);
		expected_t e;
		e.ready = (fill_edges > tag_count) && (free_q.size() > 0);
		e.tag   = (free_q.size() > 0) ? free_q[0] : '0;
		e.line  = rec[lookup];
		return e;
	endfunction

	always @(posedge clock) begin : compare_outputs
		expected_t head;
		expected_t resp;
		expected_t data;
		bit        in_ready;
		if (!rstn) begin
			free_q.delete();
			fill_edges   = 0;
			resp_pending = 1'b0;
			data_pending = 1'b0;
		end else begin
			head = predict_outputs('0);
			compare_value({test_name, " tag_ready"}, 32'(head.ready), 32'(tag_ready));
			if (head.ready) begin
				compare_value({test_name, " command_tag"}, 32'(head.tag), 32'(command_tag));
			end
			// lookups presented one edge ago
			if (resp_pending) begin
				compare_value({test_name, " response_line"}, 32'(resp_expect),
					32'(response_line));
				reads_checked++;
			end
			if (data_pending) begin
				compare_value({test_name, " data_read_line"}, 32'(data_expect),
					32'(data_read_line));
				reads_checked++;
			end
			// registered reads see the record before this edge's write
			resp         = predict_outputs(response_tag);
			data         = predict_outputs(data_read_tag);
			resp_expect  = resp.line;
			data_expect  = data.line;
			resp_pending = written[response_tag];
			data_pending = written[data_read_tag];
			in_ready = fill_edges > tag_count;
			if (!enable) begin
				// pool flushed and fill restarts while disabled
				free_q.delete();
				fill_edges = 0;
			end else begin
				// first enabled edge only leaves reset
				// then one tag per edge
				if (fill_edges >= 1 && fill_edges <= tag_count) begin
					free_q.push_back(tag_width'(fill_edges - 1));
				end
				if (in_ready && command_valid) begin
					void'(free_q.pop_front());
					rec[head.tag]     = command_line;
					written[head.tag] = 1'b1;
				end
				if (in_ready && response_valid) begin
					free_q.push_back(response_tag);
				end
				if (!in_ready) begin
					fill_edges++;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic tag_line_t random_record();
		tag_line_t l;
		l.cmd_type = cmd_type_t'($urandom_range(3));
		l.cu_id    = cu_id_width'($urandom);
		return l;
	endfunction

	// holds inputs from a falling edge over one rising edge
	task automatic drive_step(input bit issue, input tag_line_t line, input bit give_back,
		input logic [tag_width-1:0] back_tag, input logic [tag_width-1:0] lookup);
		command_valid  = issue;
		command_line   = line;
		response_valid = give_back;
		response_tag   = back_tag;
		data_read_tag  = lookup;
		if (issue) begin
			outstanding.push_back(command_tag);
		end
		@(negedge clock);
		command_valid  = 1'b0;
		response_valid = 1'b0;
	endtask

	// return every held tag in random order
	task automatic drain_outstanding();
		int                   idx;
		logic [tag_width-1:0] back;
		while (outstanding.size() > 0) begin
			idx  = $urandom_range(outstanding.size() - 1);
			back = outstanding[idx];
			outstanding.delete(idx);
			drive_step(1'b0, '0, 1'b1, back, tag_width'($urandom_range(tag_count - 1)));
		end
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	// ready latency then the whole pool issued in fill order
	task automatic fill_and_issue_in_order(input string name);
		int cycles;
		test_name = name;
		enable    = 1'b1;
		cycles    = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (!tag_ready && cycles <= tag_count + 8);
		compare_value({name, " ready latency"}, 32'(tag_count + 1), 32'(cycles));
		for (int i = 0; i < tag_count; i++) begin
			compare_value({name, " issue order"}, 32'(i), 32'(command_tag));
			drive_step(1'b1, random_record(), 1'b0, '0, '0);
		end
	endtask

	// every tag issued with no returns so the pool is empty
	task automatic exhaust_pool();
		int                   idx;
		logic [tag_width-1:0] back;
		test_name = "exhaustion";
		compare_value("exhaustion ready low", 32'(0), 32'(tag_ready));
		idx  = $urandom_range(outstanding.size() - 1);
		back = outstanding[idx];
		outstanding.delete(idx);
		drive_step(1'b0, '0, 1'b1, back, back);
		compare_value("exhaustion ready again", 32'(1), 32'(tag_ready));
		compare_value("exhaustion reissue", 32'(back), 32'(command_tag));
		drive_step(1'b1, random_record(), 1'b0, '0, back);
		compare_value("exhaustion ready low again", 32'(0), 32'(tag_ready));
		drain_outstanding();
	endtask

	task automatic lookup_records();
		test_name = "bookkeeping";
		for (int i = 0; i < book_count; i++) begin
			drive_step(1'b1, random_record(), 1'b0, '0, '0);
		end
		// each return looks its record up on port 1
		drain_outstanding();
	endtask

	task automatic read_both_ports();
		int                   ia;
		int                   ib;
		logic [tag_width-1:0] a;
		logic [tag_width-1:0] b;
		test_name = "dual read";
		for (int i = 0; i < book_count; i++) begin
			drive_step(1'b1, random_record(), 1'b0, '0, '0);
		end
		for (int i = 0; i < read_count; i++) begin
			ia = $urandom_range(outstanding.size() - 1);
			// port 2 always on a different held tag
			ib = (ia + 1 + $urandom_range(outstanding.size() - 2)) % outstanding.size();
			a  = outstanding[ia];
			b  = outstanding[ib];
			drive_step(1'b0, '0, 1'b0, a, b);
		end
		drain_outstanding();
	endtask

	task automatic random_traffic();
		bit                   issue;
		bit                   give;
		int                   idx;
		logic [tag_width-1:0] back;
		test_name = "random traffic";
		for (int c = 0; c < random_cycles; c++) begin
			// never issue without a free tag
			issue = tag_ready && ($urandom_range(1) == 1);
			give  = (outstanding.size() > 0) && ($urandom_range(2) == 0);
			back  = '0;
			if (give) begin
				idx  = $urandom_range(outstanding.size() - 1);
				back = outstanding[idx];
				outstanding.delete(idx);
			end
			drive_step(issue, random_record(), give, back,
				tag_width'($urandom_range(tag_count - 1)));
		end
		drain_outstanding();
	endtask

	task automatic reenable_pool();
		test_name = "re-enable";
		enable    = 1'b0;
		repeat (3) @(negedge clock);
		compare_value("re-enable ready low", 32'(0), 32'(tag_ready));
		// flushed tags are no longer held
		outstanding.delete();
		fill_and_issue_in_order("re-enable");
	endtask

	initial begin : stimulus
		rstn           = 1'b0;
		enable         = 1'b0;
		command_valid  = 1'b0;
		command_line   = '0;
		response_valid = 1'b0;
		response_tag   = '0;
		data_read_tag  = '0;
		reads_checked  = 0;
		test_name      = "reset";
		void'($urandom(32'hefce_846c));
		repeat (10) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		fill_and_issue_in_order("fill");
		exhaust_pool();
		lookup_records();
		read_both_ports();
		random_traffic();
		reenable_pool();
		repeat (2) @(negedge clock);
		test_name = "summary";
		compare_value("summary read checks done", 32'(1), 32'(reads_checked > 0));
		$display("Finished with no errors");
		$finish;
	end

	initial begin : watchdog
		repeat (watchdog_cycles) @(posedge clock);
		$display("timeout after %0d cycles in test %s, controller state %s",
			watchdog_cycles, test_name, i_tag_manager.i_tag_control.state.name());
		$display("Finished with errors");
		$fatal(1, "simulation did not finish in time");
	end

endmodule

// File: vlog.f
tag_pkg.sv
fifo_if.sv
tag_fifo.sv
tag_ram.sv
tag_control.sv
tag_manager.sv
tb_tag_manager.sv

// File: Makefile
TOP = tb_tag_manager

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
